//--- verilog/biu_csr_pkg.sv
// biu csr package
// widths and request word for the core to L2 CSR side-band path

package biu_csr_pkg;

  //============================================================
  // field widths
  //============================================================
  // operation code driven by the core
  localparam int csr_op_w    = 16;
  // write data of a CSR write
  localparam int csr_wdata_w = 64;
  // read data returned by the L2 on completion
  localparam int csr_rdata_w = 128;

  //============================================================
  // request word
  //============================================================
  // 80 bits in pad order, op on top and wdata below
  typedef struct packed {
    // op field, bits 79:64
    logic [csr_op_w-1:0]    op;
    // wdata field, bits 63:0
    logic [csr_wdata_w-1:0] wdata;
  } biu_csr_req_t;

endpackage : biu_csr_pkg

//--- verilog/biu_sb_pkg.sv
// biu side-band package
// widths, interrupt levels and configuration buses between pads and core

package biu_sb_pkg;

  //============================================================
  // bus widths
  //============================================================
  // physical address width for rvba and apb base
  localparam int addr_w     = 40;
  // global time counter
  localparam int time_w     = 64;
  // number of L2 perf counters
  localparam int hpcp_cnt_n = 4;
  // hart id from the pads
  localparam int hartid_w   = 3;

  //============================================================
  // interrupt levels
  //============================================================
  // machine and supervisor external, timer, software
  typedef struct packed {
    logic me;
    logic mt;
    logic ms;
    logic se;
    logic st;
    logic ss;
  } biu_irq_t;

  //============================================================
  // static configuration
  //============================================================
  // reset vector base above apb base, 80 bits total
  typedef struct packed {
    logic [addr_w-1:0] rvba;
    logic [addr_w-1:0] apb_base;
  } biu_cfg_t;

endpackage : biu_sb_pkg

//--- verilog/biu_irq_sync.sv
// biu interrupt and debug request synchronizer
// two-flop sync of pad levels into the core clock, plus wakeup indications

`timescale 1ns/1ps

module biu_irq_sync (
  input  logic                 forever_coreclk,
  input  logic                 cpurst_b,
  input  biu_sb_pkg::biu_irq_t pad_irq,
  input  logic                 pad_dbgrq_b,
  output biu_sb_pkg::biu_irq_t core_irq,
  output logic                 sdb_req_b,
  output logic                 int_wakeup,
  output logic                 dbg_wakeup
);

  import biu_sb_pkg::*;

  // first stage may go metastable, second stage is clean
  biu_irq_t irq_ff1;
  biu_irq_t irq_ff2;
  logic     dbgrq_b_ff1;
  logic     dbgrq_b_ff2;

  //============================================================
  // interrupt request levels
  //============================================================
  // all six levels idle low out of reset
  always_ff @(posedge forever_coreclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      irq_ff1 <= '0;
      irq_ff2 <= '0;
    end
    else
    begin
      irq_ff1 <= pad_irq;
      irq_ff2 <= irq_ff1;
    end
  end

  // core sees the second stage only
  assign core_irq   = irq_ff2;
  // any pending level wakes the core
  assign int_wakeup = |irq_ff2;

  //============================================================
  // debug request
  //============================================================
  // active low, so the chain idles high
  always_ff @(posedge forever_coreclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dbgrq_b_ff1 <= 1'b1;
      dbgrq_b_ff2 <= 1'b1;
    end
    else
    begin
      dbgrq_b_ff1 <= pad_dbgrq_b;
      dbgrq_b_ff2 <= dbgrq_b_ff1;
    end
  end

  assign sdb_req_b  = dbgrq_b_ff2;
  // pending debug request also wakes the core
  assign dbg_wakeup = ~dbgrq_b_ff2;

endmodule : biu_irq_sync

//--- verilog/biu_csr_bridge.sv
// biu CSR bridge
// launches one L2 CSR request per select edge, returns completion and read data

`timescale 1ns/1ps

module biu_csr_bridge (
  input  logic                                 forever_coreclk,
  input  logic                                 cpurst_b,
  // core side, select held as a level with the request
  input  logic                                 csr_sel,
  input  biu_csr_pkg::biu_csr_req_t            csr_req,
  // L2 completion
  input  logic                                 pad_csr_cmplt,
  input  logic [biu_csr_pkg::csr_rdata_w-1:0]  pad_csr_rdata,
  // L2 request
  output logic                                 pad_csr_sel,
  output biu_csr_pkg::biu_csr_req_t            pad_csr_req,
  // core return
  output logic                                 csr_cmplt,
  output logic [biu_csr_pkg::csr_rdata_w-1:0]  csr_rdata
);

  // select level seen last cycle
  logic csr_sel_ff;
  // rising edge of the held select
  logic csr_launch;

  //============================================================
  // request launch
  //============================================================
  always_ff @(posedge forever_coreclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      csr_sel_ff <= 1'b0;
    else
      csr_sel_ff <= csr_sel;
  end

  // new request only on a low to high select
  // a held level gives no second launch
  assign csr_launch = csr_sel & ~csr_sel_ff;

  // one-cycle select pulse toward the L2
  always_ff @(posedge forever_coreclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pad_csr_sel <= 1'b0;
    else
      pad_csr_sel <= csr_launch;
  end

  // request word loads with the pulse and holds until the next launch
  always_ff @(posedge forever_coreclk)
  begin
    if (csr_launch)
      pad_csr_req <= csr_req;
  end

  //============================================================
  // completion return
  //============================================================
  // strobe delayed by one cycle
  always_ff @(posedge forever_coreclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      csr_cmplt <= 1'b0;
    else
      csr_cmplt <= pad_csr_cmplt;
  end

  // read data kept until the next completion
  always_ff @(posedge forever_coreclk)
  begin
    if (pad_csr_cmplt)
      csr_rdata <= pad_csr_rdata;
  end

endmodule : biu_csr_bridge

//--- verilog/biu_sideband_regs.sv
// biu side-band registers
// registers configuration, time, power mode and perf counter signals on the core clock

`timescale 1ns/1ps

module biu_sideband_regs (
  input  logic                                  forever_coreclk,
  input  logic                                  cpurst_b,
  // slow pad buses into the core
  input  logic [biu_sb_pkg::addr_w-1:0]         pad_rvba,
  input  logic [biu_sb_pkg::addr_w-1:0]         pad_apb_base,
  input  logic [biu_sb_pkg::time_w-1:0]         pad_time,
  input  logic [biu_sb_pkg::hartid_w-1:0]       hartid,
  // power mode from cp0 and debug
  input  logic [1:0]                            cp0_lpmd_b,
  input  logic [1:0]                            had_jdb_pm,
  // perf counters
  input  logic [biu_sb_pkg::hpcp_cnt_n-1:0]     hpcp_cnt_en,
  input  logic [biu_sb_pkg::hpcp_cnt_n-1:0]     pad_l2of_int,
  output biu_sb_pkg::biu_cfg_t                  core_cfg,
  output logic [biu_sb_pkg::time_w-1:0]         core_time,
  output logic [biu_sb_pkg::hartid_w-1:0]       core_id,
  output logic [1:0]                            had_coreid,
  output logic                                  pad_lpmd_b,
  output logic                                  pad_jdb_pm,
  output logic                                  normal_work,
  output logic [biu_sb_pkg::hpcp_cnt_n-1:0]     pad_cnt_en,
  output logic [biu_sb_pkg::hpcp_cnt_n-1:0]     core_l2of_int
);

  //============================================================
  // core id
  //============================================================
  // hart id is static, no flop needed
  assign core_id    = hartid;
  // debug unit only decodes the low two bits
  assign had_coreid = hartid[1:0];

  //============================================================
  // config and time, data only
  //============================================================
  // rvba and apb base are stable long before reset release
  always_ff @(posedge forever_coreclk)
  begin
    core_cfg.rvba     <= pad_rvba;
    core_cfg.apb_base <= pad_apb_base;
    // global time sampled every cycle
    core_time         <= pad_time;
  end

  //============================================================
  // power mode out
  //============================================================
  // lpmd_b idles high, meaning normal run
  always_ff @(posedge forever_coreclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pad_lpmd_b <= 1'b1;
      pad_jdb_pm <= 1'b0;
    end
    else
    begin
      pad_lpmd_b <= cp0_lpmd_b[0];
      pad_jdb_pm <= had_jdb_pm[1];
    end
  end

  // core is working whenever no low power mode is requested
  assign normal_work = pad_lpmd_b;

  //============================================================
  // perf counter controls, both directions
  //============================================================
  always_ff @(posedge forever_coreclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pad_cnt_en    <= '0;
      core_l2of_int <= '0;
    end
    else
    begin
      // enables toward the L2 counters
      pad_cnt_en    <= hpcp_cnt_en;
      // overflow interrupts back to the core
      core_l2of_int <= pad_l2of_int;
    end
  end

endmodule : biu_sideband_regs

//--- verilog/biu_io_sync_top.sv
// biu side-band io synchronizer
// joins interrupt sync, CSR bridge and side-band registers between pads and core

`timescale 1ns/1ps

module biu_io_sync_top (
  input  logic                                  forever_coreclk,
  input  logic                                  cpurst_b,
  // interrupts and debug request
  input  biu_sb_pkg::biu_irq_t                  pad_irq,
  input  logic                                  pad_dbgrq_b,
  output biu_sb_pkg::biu_irq_t                  core_irq,
  output logic                                  sdb_req_b,
  output logic                                  int_wakeup,
  output logic                                  dbg_wakeup,
  // CSR path to the L2
  input  logic                                  csr_sel,
  input  biu_csr_pkg::biu_csr_req_t             csr_req,
  input  logic                                  pad_csr_cmplt,
  input  logic [biu_csr_pkg::csr_rdata_w-1:0]   pad_csr_rdata,
  output logic                                  pad_csr_sel,
  output biu_csr_pkg::biu_csr_req_t             pad_csr_req,
  output logic                                  csr_cmplt,
  output logic [biu_csr_pkg::csr_rdata_w-1:0]   csr_rdata,
  // configuration and status
  input  logic [biu_sb_pkg::addr_w-1:0]         pad_rvba,
  input  logic [biu_sb_pkg::addr_w-1:0]         pad_apb_base,
  input  logic [biu_sb_pkg::time_w-1:0]         pad_time,
  input  logic [biu_sb_pkg::hartid_w-1:0]       hartid,
  input  logic [1:0]                            cp0_lpmd_b,
  input  logic [1:0]                            had_jdb_pm,
  input  logic [biu_sb_pkg::hpcp_cnt_n-1:0]     hpcp_cnt_en,
  input  logic [biu_sb_pkg::hpcp_cnt_n-1:0]     pad_l2of_int,
  output biu_sb_pkg::biu_cfg_t                  core_cfg,
  output logic [biu_sb_pkg::time_w-1:0]         core_time,
  output logic [biu_sb_pkg::hartid_w-1:0]       core_id,
  output logic [1:0]                            had_coreid,
  output logic                                  pad_lpmd_b,
  output logic                                  pad_jdb_pm,
  output logic                                  normal_work,
  output logic [biu_sb_pkg::hpcp_cnt_n-1:0]     pad_cnt_en,
  output logic [biu_sb_pkg::hpcp_cnt_n-1:0]     core_l2of_int
);

  //============================================================
  // interrupt and debug sync, 2 cycles
  //============================================================
  biu_irq_sync u_irq_sync (
    .forever_coreclk (forever_coreclk),
    .cpurst_b        (cpurst_b),
    .pad_irq         (pad_irq),
    .pad_dbgrq_b     (pad_dbgrq_b),
    .core_irq        (core_irq),
    .sdb_req_b       (sdb_req_b),
    .int_wakeup      (int_wakeup),
    .dbg_wakeup      (dbg_wakeup)
  );

  //============================================================
  // CSR request and completion, 1 cycle each way
  //============================================================
  biu_csr_bridge u_csr_bridge (
    .forever_coreclk (forever_coreclk),
    .cpurst_b        (cpurst_b),
    .csr_sel         (csr_sel),
    .csr_req         (csr_req),
    .pad_csr_cmplt   (pad_csr_cmplt),
    .pad_csr_rdata   (pad_csr_rdata),
    .pad_csr_sel     (pad_csr_sel),
    .pad_csr_req     (pad_csr_req),
    .csr_cmplt       (csr_cmplt),
    .csr_rdata       (csr_rdata)
  );

  //============================================================
  // config, time, power mode, counters
  //============================================================
  biu_sideband_regs u_sideband_regs (
    .forever_coreclk (forever_coreclk),
    .cpurst_b        (cpurst_b),
    .pad_rvba        (pad_rvba),
    .pad_apb_base    (pad_apb_base),
    .pad_time        (pad_time),
    .hartid          (hartid),
    .cp0_lpmd_b      (cp0_lpmd_b),
    .had_jdb_pm      (had_jdb_pm),
    .hpcp_cnt_en     (hpcp_cnt_en),
    .pad_l2of_int    (pad_l2of_int),
    .core_cfg        (core_cfg),
    .core_time       (core_time),
    .core_id         (core_id),
    .had_coreid      (had_coreid),
    .pad_lpmd_b      (pad_lpmd_b),
    .pad_jdb_pm      (pad_jdb_pm),
    .normal_work     (normal_work),
    .pad_cnt_en      (pad_cnt_en),
    .core_l2of_int   (core_l2of_int)
  );

endmodule : biu_io_sync_top

//--- bench/tb_biu_io_sync.sv
// testbench for the biu side-band io synchronizer
// table of interrupt, debug, CSR and side-band rows applied in a loop

`timescale 1ns/1ps

module tb_biu_io_sync;

  import biu_sb_pkg::*;
  import biu_csr_pkg::*;

  // one stimulus row of 36 bits
  typedef struct packed {
    logic [5:0]  irq;
    logic        dbgrq_b;
    logic [15:0] op;
    logic        cmplt;
    logic [3:0]  cnt_en;
    logic [3:0]  l2of;
    logic [1:0]  lpmd;
    logic [1:0]  jdb_pm;
  } row_t;

  localparam int n_rows = 8;
  // irq order me mt ms se st ss
  // each bit in turn then all then none
  localparam row_t test_tbl [0:n_rows-1] = '{
    {6'b100000, 1'b1, 16'h0101, 1'b1, 4'h1, 4'h8, 2'b11, 2'b00},
    {6'b010000, 1'b1, 16'h0202, 1'b0, 4'h2, 4'h4, 2'b10, 2'b10},
    {6'b001000, 1'b0, 16'h0303, 1'b1, 4'h4, 4'h2, 2'b01, 2'b11},
    {6'b000100, 1'b1, 16'h0404, 1'b1, 4'h8, 4'h1, 2'b00, 2'b01},
    {6'b000010, 1'b1, 16'h0505, 1'b0, 4'h3, 4'hc, 2'b11, 2'b10},
    {6'b000001, 1'b0, 16'h0606, 1'b1, 4'hc, 4'h3, 2'b10, 2'b00},
    {6'b111111, 1'b0, 16'h0707, 1'b1, 4'hf, 4'hf, 2'b01, 2'b11},
    {6'b000000, 1'b1, 16'h0808, 1'b1, 4'h0, 4'h5, 2'b11, 2'b00}
  };

  logic                       forever_coreclk;
  logic                       cpurst_b;
  biu_irq_t                   pad_irq;
  logic                       pad_dbgrq_b;
  biu_irq_t                   core_irq;
  logic                       sdb_req_b;
  logic                       int_wakeup;
  logic                       dbg_wakeup;
  logic                       csr_sel;
  biu_csr_req_t               csr_req;
  logic                       pad_csr_cmplt;
  logic [csr_rdata_w-1:0]     pad_csr_rdata;
  logic                       pad_csr_sel;
  biu_csr_req_t               pad_csr_req;
  logic                       csr_cmplt;
  logic [csr_rdata_w-1:0]     csr_rdata;
  logic [addr_w-1:0]          pad_rvba;
  logic [addr_w-1:0]          pad_apb_base;
  logic [time_w-1:0]          pad_time;
  logic [hartid_w-1:0]        hartid;
  logic [1:0]                 cp0_lpmd_b;
  logic [1:0]                 had_jdb_pm;
  logic [hpcp_cnt_n-1:0]      hpcp_cnt_en;
  logic [hpcp_cnt_n-1:0]      pad_l2of_int;
  biu_cfg_t                   core_cfg;
  logic [time_w-1:0]          core_time;
  logic [hartid_w-1:0]        core_id;
  logic [1:0]                 had_coreid;
  logic                       pad_lpmd_b;
  logic                       pad_jdb_pm;
  logic                       normal_work;
  logic [hpcp_cnt_n-1:0]      pad_cnt_en;
  logic [hpcp_cnt_n-1:0]      core_l2of_int;

  int          err_count = 0;
  int          failed_tests = 0;
  logic [31:0] lfsr_state = 32'h184c;

  biu_io_sync_top uut (.*);

  // 40 ns core clock
  initial
  begin
    forever_coreclk = 1'b0;
    forever #20 forever_coreclk = ~forever_coreclk;
  end

  //============================================================
  // helpers
  //============================================================
  // fibonacci lfsr with taps 32 22 2 1
  // one step per bit
  function logic rand_bit();
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    return lfsr_state[0];
  endfunction

  function logic [127:0] rand_bits(input int n);
    logic [127:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
      v[k] = rand_bit();
    return v;
  endfunction

  task report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    err_count++;
  endtask

  // bounded wait for one pulse then a count of extra pulses
  task automatic wait_pulse(input bit on_cmplt, input string name, output int extra);
    int  n;
    bit  found;
    found = 1'b0;
    n = 0;
    extra = 0;
    while (!found && n < 10)
    begin
      @(negedge forever_coreclk);
      n++;
      found = on_cmplt ? csr_cmplt : pad_csr_sel;
    end
    if (!found)
    begin
      $display("timeout: no %s pulse seen within 10 cycles at %0t ns", name, $time);
      err_count++;
    end
    repeat (4)
    begin
      @(negedge forever_coreclk);
      if (on_cmplt ? csr_cmplt : pad_csr_sel)
        extra++;
    end
  endtask

  task check_reset_values(input string tag);
    if (core_irq !== '0 || sdb_req_b !== 1'b1 || int_wakeup !== 1'b0 || dbg_wakeup !== 1'b0)
      report_error({tag, ": irq sync outputs not at reset values"});
    if (pad_csr_sel !== 1'b0 || csr_cmplt !== 1'b0)
      report_error({tag, ": csr strobes not low"});
    if (pad_lpmd_b !== 1'b1 || normal_work !== 1'b1 || pad_jdb_pm !== 1'b0 || pad_cnt_en !== '0)
      report_error({tag, ": power mode or counter enables not at reset values"});
  endtask

  //============================================================
  // main sequence
  //============================================================
  initial
  begin
    row_t              row;
    biu_csr_req_t      exp_req;
    biu_cfg_t          exp_cfg;
    logic [time_w-1:0] exp_time;
    logic [2:0]        exp_hartid;
    logic [127:0]      rnd;
    int                extra;
    int                row_err;
    // inputs away from idle while reset holds the outputs
    cpurst_b      = 1'b0;
    pad_irq       = '1;
    pad_dbgrq_b   = 1'b0;
    csr_sel       = 1'b1;
    csr_req       = '0;
    pad_csr_cmplt = 1'b1;
    pad_csr_rdata = '0;
    pad_rvba      = '0;
    pad_apb_base  = '0;
    pad_time      = '0;
    hartid        = '0;
    cp0_lpmd_b    = 2'b10;
    had_jdb_pm    = 2'b10;
    hpcp_cnt_en   = '1;
    pad_l2of_int  = '0;

    // reset held 16 cycles and checked midway and after release
    repeat (8) @(posedge forever_coreclk);
    @(negedge forever_coreclk);
    check_reset_values("during reset");
    repeat (8) @(posedge forever_coreclk);
    cpurst_b      <= 1'b1;
    pad_irq       <= '0;
    pad_dbgrq_b   <= 1'b1;
    csr_sel       <= 1'b0;
    pad_csr_cmplt <= 1'b0;
    cp0_lpmd_b    <= 2'b11;
    had_jdb_pm    <= 2'b00;
    hpcp_cnt_en   <= '0;
    @(negedge forever_coreclk);
    check_reset_values("after reset");
    if (err_count != 0)
      failed_tests++;
    $display("test reset: %s", (err_count == 0) ? "ok" : "mismatch");

    for (int i = 0; i < n_rows; i++)
    begin
      row_err = err_count;
      row = test_tbl[i];
      rnd = rand_bits(64);
      exp_req = {row.op, rnd[63:0]};
      rnd = rand_bits(40);
      exp_cfg.rvba = rnd[39:0];
      rnd = rand_bits(40);
      exp_cfg.apb_base = rnd[39:0];
      rnd = rand_bits(64);
      exp_time = rnd[63:0];
      rnd = rand_bits(3);
      exp_hartid = rnd[2:0];

      @(posedge forever_coreclk);
      pad_irq      <= row.irq;
      pad_dbgrq_b  <= row.dbgrq_b;
      csr_sel      <= 1'b1;
      csr_req      <= exp_req;
      pad_rvba     <= exp_cfg.rvba;
      pad_apb_base <= exp_cfg.apb_base;
      pad_time     <= exp_time;
      hartid       <= exp_hartid;
      cp0_lpmd_b   <= row.lpmd;
      had_jdb_pm   <= row.jdb_pm;
      hpcp_cnt_en  <= row.cnt_en;
      pad_l2of_int <= row.l2of;

      // select held through the whole window gives one launch only
      wait_pulse(1'b0, "pad_csr_sel", extra);
      if (extra != 0)
        report_error($sformatf("%0d extra pad_csr_sel pulses while csr_sel held", extra));
      if (pad_csr_req !== exp_req)
        report_error($sformatf("pad_csr_req %h, expected %h", pad_csr_req, exp_req));

      // at least 5 cycles since the row went out
      if (core_irq !== row.irq || int_wakeup !== (|row.irq))
        report_error($sformatf("core_irq %b wakeup %b, expected %b", core_irq,
                               int_wakeup, row.irq));
      if (sdb_req_b !== row.dbgrq_b || dbg_wakeup !== !row.dbgrq_b)
        report_error($sformatf("sdb_req_b %b dbg_wakeup %b, dbgrq_b %b", sdb_req_b,
                               dbg_wakeup, row.dbgrq_b));
      if (core_cfg !== exp_cfg || core_time !== exp_time || core_l2of_int !== row.l2of)
        report_error("core_cfg, core_time or core_l2of_int differ from pad inputs");
      if (pad_cnt_en !== row.cnt_en || pad_jdb_pm !== row.jdb_pm[1])
        report_error($sformatf("pad_cnt_en %h pad_jdb_pm %b wrong", pad_cnt_en, pad_jdb_pm));
      if (pad_lpmd_b !== row.lpmd[0] || normal_work !== row.lpmd[0])
        report_error($sformatf("pad_lpmd_b %b normal_work %b, expected %b", pad_lpmd_b,
                               normal_work, row.lpmd[0]));
      if (core_id !== exp_hartid || had_coreid !== exp_hartid[1:0])
        report_error($sformatf("core_id %h had_coreid %h, hartid %h", core_id,
                               had_coreid, exp_hartid));

      // core moves on to another word and the launched one stays
      @(posedge forever_coreclk);
      csr_sel <= 1'b0;
      csr_req <= ~exp_req;
      @(posedge forever_coreclk);
      @(negedge forever_coreclk);
      if (pad_csr_req !== exp_req)
        report_error($sformatf("pad_csr_req %h changed without a launch", pad_csr_req));

      if (row.cmplt)
      begin
        rnd = rand_bits(128);
        @(posedge forever_coreclk);
        pad_csr_cmplt <= 1'b1;
        pad_csr_rdata <= rnd;
        // rdata moves on without a strobe and the capture holds
        @(posedge forever_coreclk);
        pad_csr_cmplt <= 1'b0;
        pad_csr_rdata <= ~rnd;
        wait_pulse(1'b1, "csr_cmplt", extra);
        if (extra != 0)
          report_error($sformatf("%0d extra csr_cmplt pulses", extra));
        if (csr_rdata !== rnd)
          report_error($sformatf("csr_rdata %h, expected %h", csr_rdata, rnd));
      end

      if (err_count != row_err)
        failed_tests++;
      $display("test row %0d irq %b op %h: %s", i, row.irq, row.op,
               (err_count == row_err) ? "ok" : "mismatch");
    end

    $display("tests %0d, failed %0d, errors %0d", n_rows + 1, failed_tests, err_count);
    if (err_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : tb_biu_io_sync

//--- vlog.f
verilog/biu_csr_pkg.sv
verilog/biu_sb_pkg.sv
verilog/biu_irq_sync.sv
verilog/biu_csr_bridge.sv
verilog/biu_sideband_regs.sv
verilog/biu_io_sync_top.sv
bench/tb_biu_io_sync.sv

//--- Bender.yml
package:
  name: biu_io_sync

sources:
  # packages first
  - verilog/biu_csr_pkg.sv
  - verilog/biu_sb_pkg.sv
  # side-band blocks
  - verilog/biu_irq_sync.sv
  - verilog/biu_csr_bridge.sv
  - verilog/biu_sideband_regs.sv
  # top level
  - verilog/biu_io_sync_top.sv
  - target: simulation
    files:
      - bench/tb_biu_io_sync.sv
